//--- compile.f
design/cart_pkg.sv
design/bus_sync.sv
design/address_decoder.sv
design/rom_req_queue.sv
design/cart_regs.sv
design/cart_top.sv
bench/address_decoder_chk.sv
bench/cart_tb.sv

//--- bench/cart_tb.sv
// Console cycles are 6 to 7 clocks long, so at most a few ROM reads are ever in flight.
// The memory model returns one credit per request after 1 to 8 cycles unless held.
`timescale 1ns/100ps

module cart_tb import cart_pkg::*; ();

  localparam int          CLK_PERIOD        = 20;
  localparam int          RANDOM_ACCESSES   = 300;
  localparam int          ACCESS_BUDGET     = RANDOM_ACCESSES + 100;
  localparam int          CYCLES_PER_ACCESS = 8;
  localparam logic [31:0] SEED              = 32'heec7_d6dc;

  logic CLK, rst;
  logic [23:0] snes_addr;
  logic [7:0] snes_pa, snes_data, snes_rdata, ppu_2100;
  logic snes_romsel, snes_rd_n, snes_wr_n, snes_rdata_oe;
  logic feature_wr, rom_credit, rom_req_valid, msu_sel, sgb_sel, overflow;
  logic [15:0] feature_data, pad_buttons;
  rom_req_t rom_req;

  // Reference model state
  int          cyc = 0;
  int          outstanding = 0;
  int          pending[$];
  logic [23:0] exp_addr[$];
  int          exp_cyc[$];
  logic        hold_credits = 1'b0;
  logic        drop_expected = 1'b0;
  logic        overflow_armed = 1'b0;
  logic [15:0] feat = '0;
  logic [7:0]  ppu_exp = '0;
  logic [7:0]  cmd_model [512];
  bit          cmd_written [512];

  cart_top i_dut (.*);

  bind address_decoder address_decoder_chk i_decode_chk (
    .CLK         (cart_tb.CLK),
    .rst         (cart_tb.rst),
    .bus         (bus),
    .featurebits (featurebits),
    .decode      (decode)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  function automatic logic [23:0] fold_rom_addr(input logic [23:0] a);
    return {5'd0, a[19:16], a[14:0]};
  endfunction

  function automatic logic in_cmd_window(input logic [23:0] a);
    return {a[22], a[15:9]} == SNESCMD_PAGE;
  endfunction

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  initial begin
    #(ACCESS_BUDGET * CYCLES_PER_ACCESS * CLK_PERIOD);
    stop_with_failure("Watchdog expired before the tests finished");
  end

  credit_limit: assert property (@(posedge CLK) disable iff (rst) outstanding <= ROM_CREDITS)
    else stop_with_failure($sformatf("Fail at %0t: %0d requests outstanding", $time, outstanding));

  no_early_overflow: assert property (@(posedge CLK) disable iff (rst)
      !overflow_armed |-> !overflow)
    else stop_with_failure($sformatf("Fail at %0t: overflow set with room in the queue", $time));

  reset_values: assert property (@(posedge CLK)
      rst |=> !rom_req_valid && !snes_rdata_oe && !overflow)
    else stop_with_failure($sformatf("Fail at %0t: outputs not cleared by reset", $time));

  known_outputs: assert property (@(posedge CLK) disable iff (rst)
      !$isunknown({rom_req_valid, snes_rdata_oe, overflow, msu_sel, sgb_sel, ppu_2100}))
    else stop_with_failure($sformatf("Fail at %0t: control output is unknown", $time));

  decoder_rules: assert property (@(posedge CLK)
      i_dut.u_address_decoder.i_decode_chk.fail_count == 0)
    else stop_with_failure("The bound decoder checker flagged a broken decode rule");

  // Memory controller model
  always @(posedge CLK) begin
    int idx;
    #2;
    rom_credit = 1'b0;
    idx = -1;
    for (int i = 0; i < pending.size(); i++) begin
      if (pending[i] > 0) pending[i] = pending[i] - 1;
      if (pending[i] == 0 && idx < 0) idx = i;
    end
    if (!rst && !hold_credits && idx >= 0) begin
      pending.delete(idx);
      rom_credit = 1'b1;
      outstanding = outstanding - 1;
    end
  end

  // ROM requests must come out in order with the folded address
  always @(negedge CLK) begin
    logic [23:0] want;
    int          edge_cyc;
    if (!rst && rom_req_valid === 1'b1) begin
      assert (exp_addr.size() > 0) else stop_with_failure($sformatf(
        "Fail at %0t: unexpected ROM request 0x%06h", $time, rom_req.rom_addr));
      want = exp_addr.pop_front();
      edge_cyc = exp_cyc.pop_front();
      assert (rom_req.rom_addr === want) else stop_with_failure($sformatf(
        "Fail at %0t: ROM request 0x%06h, expected 0x%06h", $time, rom_req.rom_addr, want));
      assert (cyc - edge_cyc >= 4) else stop_with_failure($sformatf(
        "Fail at %0t: ROM request only %0d cycles after the strobe", $time, cyc - edge_cyc));
      outstanding = outstanding + 1;
      pending.push_back($urandom_range(1, 8));
    end
  end

  task automatic load_features(input logic [15:0] bits);
    @(posedge CLK);
    #2;
    feature_wr = 1'b1;
    feature_data = bits;
    @(posedge CLK);
    #2;
    feature_wr = 1'b0;
    feat = bits;
  endtask

  // One console cycle, checked 4 clocks after the strobe edge
  task automatic console_access(input logic [23:0] addr, input logic [7:0] pa,
                                input logic romsel, input logic wr, input logic [7:0] wdata);
    logic       bbus, exp_oe, exp_msu, exp_sgb, check_data;
    logic [7:0] exp_data;
    @(posedge CLK);
    #2;
    snes_addr = addr;
    snes_pa = pa;
    snes_romsel = romsel;
    snes_data = wdata;
    @(posedge CLK);
    #2;
    if (wr) snes_wr_n = 1'b0;
    else snes_rd_n = 1'b0;
    if (!wr && !romsel && !drop_expected) begin
      exp_addr.push_back(fold_rom_addr(addr));
      exp_cyc.push_back(cyc);
    end
    repeat (4) @(posedge CLK);
    #2;
    bbus = !addr[22] && addr[15:8] == 8'h21;
    if (wr && in_cmd_window(addr)) begin
      cmd_model[addr[8:0]] = wdata;
      cmd_written[addr[8:0]] = 1'b1;
    end
    if (wr && bbus && pa == 8'h00) ppu_exp = wdata;
    exp_oe = 1'b0;
    check_data = 1'b0;
    exp_data = '0;
    if (!wr && in_cmd_window(addr)) begin
      exp_oe = 1'b1;
      check_data = cmd_written[addr[8:0]];
      exp_data = cmd_model[addr[8:0]];
    end else if (!wr && (addr == BUTTON_BASE + 24'd1 || addr == BUTTON_BASE + 24'd2)) begin
      // Offset 1 returns the high pad byte
      exp_oe = 1'b1;
      check_data = 1'b1;
      exp_data = (addr == BUTTON_BASE + 24'd1) ? pad_buttons[15:8] : pad_buttons[7:0];
    end else if (!wr && feat[FEAT_213F] && bbus && pa == 8'h3f) begin
      exp_oe = 1'b1;
      check_data = 1'b1;
      exp_data = R213F_VALUE;
      exp_data[R213F_REGION_BIT] = feat[0];
    end
    exp_msu = feat[FEAT_MSU] && !addr[22] && addr[15:0] >= 16'h2000 && addr[15:0] <= 16'h2007;
    // SGB answers at $7000-$7FFF and in $6000-$67FF where bit 3 is clear or the nibble is $F
    exp_sgb = !addr[22] && (addr[15:12] == 4'h7 ||
              (addr[15:11] == 5'b01100 && (!addr[3] || addr[3:0] == 4'hf)));
    assert (snes_rdata_oe === exp_oe) else stop_with_failure($sformatf(
      "Fail at %0t: oe %b, expected %b at 0x%06h", $time, snes_rdata_oe, exp_oe, addr));
    assert (!check_data || snes_rdata === exp_data) else stop_with_failure($sformatf(
      "Fail at %0t: read 0x%02h, expected 0x%02h at 0x%06h", $time, snes_rdata, exp_data, addr));
    assert (msu_sel === exp_msu) else stop_with_failure($sformatf(
      "Fail at %0t: msu_sel %b, expected %b at 0x%06h", $time, msu_sel, exp_msu, addr));
    assert (sgb_sel === exp_sgb) else stop_with_failure($sformatf(
      "Fail at %0t: sgb_sel %b, expected %b at 0x%06h", $time, sgb_sel, exp_sgb, addr));
    assert (ppu_2100 === ppu_exp) else stop_with_failure($sformatf(
      "Fail at %0t: ppu_2100 0x%02h, expected 0x%02h", $time, ppu_2100, ppu_exp));
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
  endtask

  task automatic random_access();
    logic [23:0] addr;
    logic [7:0]  pa;
    logic        romsel, wr;
    addr = 24'($urandom());
    pa = 8'($urandom());
    romsel = 1'($urandom_range(0, 1));
    wr = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 6))
      1: begin
        romsel = 1'b0;
        wr = 1'b0;
      end
      2: addr = {addr[23], 1'b0, addr[21:16], 7'b0010101, addr[8:0]};
      3: addr = BUTTON_BASE + 24'(addr[1:0]);
      4: begin
        addr = {addr[23], 1'b0, addr[21:16], 8'h21, addr[7:0]};
        pa = pa[0] ? 8'h3f : (pa[1] ? 8'h00 : pa);
      end
      5: addr = {addr[23], 1'b0, addr[21:16], 3'b011, addr[12:0]};
      6: addr = {addr[23], 1'b0, addr[21:16], 12'h200, addr[3:0]};
      default: ;
    endcase
    console_access(addr, pa, romsel, wr, 8'($urandom()));
  endtask

  task automatic wait_rom_drain();
    while (exp_addr.size() != 0 || outstanding != 0 || pending.size() != 0) @(posedge CLK);
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    snes_addr = '0;
    snes_pa = '0;
    snes_romsel = 1'b1;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_data = '0;
    feature_wr = 1'b0;
    feature_data = '0;
    pad_buttons = '0;
    rom_credit = 1'b0;
    repeat (10) @(posedge CLK);
    #2;
    rst = 1'b0;

    // Features clear, so $213F stays silent and MSU never selects
    console_access(24'h00213f, 8'h3f, 1'b1, 1'b0, 8'h00);
    console_access(24'h002003, 8'h00, 1'b1, 1'b1, 8'h5a);
    load_features(16'h0019);
    console_access(24'h00213f, 8'h3f, 1'b1, 1'b0, 8'h00);
    console_access(24'h802005, 8'h00, 1'b1, 1'b0, 8'h00);
    pad_buttons = 16'hc3a5;
    console_access(BUTTON_BASE + 24'd1, 8'h00, 1'b1, 1'b0, 8'h00);
    console_access(BUTTON_BASE + 24'd2, 8'h00, 1'b1, 1'b0, 8'h00);
    console_access(24'h002a10, 8'h00, 1'b1, 1'b1, 8'h6b);
    console_access(24'h802b7f, 8'h00, 1'b1, 1'b1, 8'h94);
    console_access(24'h002a10, 8'h00, 1'b1, 1'b0, 8'h00);
    console_access(24'h802b7f, 8'h00, 1'b1, 1'b0, 8'h00);
    console_access(24'h002100, 8'h00, 1'b1, 1'b1, 8'h8f);
    console_access(24'hc01234, 8'h00, 1'b0, 1'b0, 8'h00);
    console_access(24'h808000, 8'h00, 1'b0, 1'b0, 8'h00);
    console_access(24'h3fffff, 8'h00, 1'b0, 1'b0, 8'h00);
    wait_rom_drain();

    // Withheld credits fill the queue, then one more read is dropped
    hold_credits = 1'b1;
    for (int i = 0; i < ROM_CREDITS + ROM_QUEUE_DEPTH; i++) begin
      console_access(24'h908000 + 24'(i * 2), 8'h00, 1'b0, 1'b0, 8'h00);
    end
    drop_expected = 1'b1;
    overflow_armed = 1'b1;
    console_access(24'h90fffe, 8'h00, 1'b0, 1'b0, 8'h00);
    drop_expected = 1'b0;
    assert (overflow === 1'b1) else stop_with_failure($sformatf(
      "Fail at %0t: overflow not set after a read into a full queue", $time));
    hold_credits = 1'b0;
    wait_rom_drain();

    pad_buttons = 16'($urandom());
    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      random_access();
    end
    wait_rom_drain();

    if (i_dut.u_address_decoder.i_decode_chk.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure("The bound decoder checker flagged a broken decode rule");
    end
  end

endmodule

//--- bench/address_decoder_chk.sv
// Bound to address_decoder and sampled on the testbench clock passed in by the bind.
// Rules are checked once the bus snapshot holds a real access.
`timescale 1ns/100ps

module address_decoder_chk import cart_pkg::*; (
  input logic        CLK,
  input logic        rst,
  input snes_bus_t   bus,
  input logic [15:0] featurebits,
  input decode_t     decode
);

  int unsigned fail_count = 0;
  logic        live;
  logic [15:0] low;

  assign live = !rst && !$isunknown(bus);
  assign low  = bus.addr[15:0];

  no_x_decode: assert property (@(posedge CLK) live |-> !$isunknown(decode))
    else begin
      fail_count = fail_count + 1;
      $error("Decoder output has unknown bits");
    end

  // Save-RAM is absent, so every ROMSEL cycle is a ROM hit
  rom_select: assert property (@(posedge CLK) live |->
      decode.is_rom == !bus.romsel && decode.rom_hit == decode.is_rom &&
      !decode.is_saveram && !decode.is_writable)
    else begin
      fail_count = fail_count + 1;
      $error("ROM or save-RAM select does not follow ROMSEL");
    end

  rom_fold: assert property (@(posedge CLK) live |->
      decode.rom_addr == {5'd0, bus.addr[19:16], bus.addr[14:0]})
    else begin
      fail_count = fail_count + 1;
      $error("Folded ROM address is wrong");
    end

  msu_window: assert property (@(posedge CLK) live |-> decode.msu_enable ==
      (featurebits[FEAT_MSU] && !bus.addr[22] && low >= 16'h2000 && low <= 16'h2007))
    else begin
      fail_count = fail_count + 1;
      $error("MSU select is wrong");
    end

  sgb_window: assert property (@(posedge CLK) live |-> decode.sgb_enable ==
      (!bus.addr[22] && (((low & SGB_MASK_A) == SGB_BASE_A) ||
                         ((low & SGB_MASK_B) == SGB_BASE_B) ||
                         ((low & SGB_MASK_C) == SGB_BASE_C))))
    else begin
      fail_count = fail_count + 1;
      $error("SGB select is wrong");
    end

  pa_regs: assert property (@(posedge CLK) live |->
      decode.r213f_enable == (featurebits[FEAT_213F] && bus.pa == 8'h3f) &&
      decode.r2100_hit == (bus.pa == 8'h00))
    else begin
      fail_count = fail_count + 1;
      $error("B-bus register decode is wrong");
    end

  cmd_window: assert property (@(posedge CLK) live |->
      decode.snescmd_enable == ({bus.addr[22], bus.addr[15:9]} == SNESCMD_PAGE))
    else begin
      fail_count = fail_count + 1;
      $error("Command window select is wrong");
    end

  // Offset 1 is the byte with button_addr set
  buttons: assert property (@(posedge CLK) live |->
      decode.button_enable ==
        (bus.addr == BUTTON_BASE + 24'd1 || bus.addr == BUTTON_BASE + 24'd2) &&
      (!decode.button_enable || decode.button_addr == (bus.addr == BUTTON_BASE + 24'd1)))
    else begin
      fail_count = fail_count + 1;
      $error("Button decode is wrong");
    end

endmodule

//--- design/cart_top.sv
// ROM read data comes back from the memory controller outside this block.
`timescale 1ns/100ps

module cart_top import cart_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  // Console bus
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_pa,
  input  logic        snes_romsel,
  input  logic        snes_rd_n,
  input  logic        snes_wr_n,
  input  logic [7:0]  snes_data,
  output logic [7:0]  snes_rdata,
  output logic        snes_rdata_oe,
  // Host
  input  logic        feature_wr,
  input  logic [15:0] feature_data,
  input  logic [15:0] pad_buttons,
  // Memory controller
  output logic        rom_req_valid,
  output rom_req_t    rom_req,
  input  logic        rom_credit,
  // Status
  output logic [7:0]  ppu_2100,
  output logic        msu_sel,
  output logic        sgb_sel,
  output logic        overflow
);

  logic        access_valid;
  access_t     access;
  decode_t     decode;
  logic [15:0] featurebits;

  bus_sync u_bus_sync (
    .CLK          (CLK),
    .rst          (rst),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_romsel  (snes_romsel),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_data    (snes_data),
    .access_valid (access_valid),
    .access       (access)
  );

  address_decoder u_address_decoder (
    .bus         (access.bus),
    .featurebits (featurebits),
    .decode      (decode)
  );

  rom_req_queue u_rom_req_queue (
    .CLK           (CLK),
    .rst           (rst),
    .access_valid  (access_valid),
    .access        (access),
    .decode        (decode),
    .rom_credit    (rom_credit),
    .rom_req_valid (rom_req_valid),
    .rom_req       (rom_req),
    .overflow      (overflow)
  );

  cart_regs u_cart_regs (
    .CLK           (CLK),
    .rst           (rst),
    .access_valid  (access_valid),
    .access        (access),
    .decode        (decode),
    .feature_wr    (feature_wr),
    .feature_data  (feature_data),
    .pad_buttons   (pad_buttons),
    .featurebits   (featurebits),
    .ppu_2100      (ppu_2100),
    .msu_sel       (msu_sel),
    .sgb_sel       (sgb_sel),
    .snes_rdata    (snes_rdata),
    .snes_rdata_oe (snes_rdata_oe)
  );

endmodule

//--- design/cart_regs.sv
// $2100 capture and $213F reads need a B-bus cycle ($21xx) with the matching PA.
// Read data and oe update on every console access and hold in between.
`timescale 1ns/100ps

module cart_regs import cart_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  logic        access_valid,
  input  access_t     access,
  input  decode_t     decode,
  input  logic        feature_wr,
  input  logic [15:0] feature_data,
  input  logic [15:0] pad_buttons,
  output logic [15:0] featurebits,
  output logic [7:0]  ppu_2100,
  output logic        msu_sel,
  output logic        sgb_sel,
  output logic [7:0]  snes_rdata,
  output logic        snes_rdata_oe
);

  logic [7:0]            cmd_ram [CMD_RAM_BYTES];
  logic [CMD_ADDR_W-1:0] cmd_idx;
  logic                  rd_access;
  logic                  wr_access;
  logic                  r213f_rd;
  logic                  r2100_wr;
  logic                  rd_claim;
  logic [7:0]            r213f_value;
  logic [7:0]            button_byte;

  assign cmd_idx   = access.bus.addr[CMD_ADDR_W-1:0];
  assign rd_access = access_valid && !access.wr;
  assign wr_access = access_valid && access.wr;
  assign r213f_rd  = decode.r213f_enable && access.pa_cycle;
  assign r2100_wr  = wr_access && decode.r2100_hit && access.pa_cycle;

  // Reads the cartridge answers, anything else is left to the memory controller
  assign rd_claim = decode.snescmd_enable || decode.button_enable || r213f_rd;

  always_comb begin
    r213f_value = R213F_VALUE;
    r213f_value[R213F_REGION_BIT] = featurebits[FEAT_REGION];
  end

  // button_addr low picks the low pad byte
  assign button_byte = decode.button_addr ? pad_buttons[15:8] : pad_buttons[7:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      featurebits   <= '0;
      ppu_2100      <= '0;
      msu_sel       <= 1'b0;
      sgb_sel       <= 1'b0;
      snes_rdata_oe <= 1'b0;
    end else begin
      if (feature_wr) begin
        featurebits <= feature_data;
      end
      if (r2100_wr) begin
        ppu_2100 <= access.wdata;
      end
      msu_sel <= access_valid && decode.msu_enable;
      sgb_sel <= access_valid && decode.sgb_enable;
      if (access_valid) begin
        snes_rdata_oe <= rd_access && rd_claim;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_access && decode.snescmd_enable) begin
      cmd_ram[cmd_idx] <= access.wdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_access) begin
      if (decode.snescmd_enable) begin
        snes_rdata <= cmd_ram[cmd_idx];
      end else if (decode.button_enable) begin
        snes_rdata <= button_byte;
      end else if (r213f_rd) begin
        snes_rdata <= r213f_value;
      end else begin
        snes_rdata <= '0;
      end
    end
  end

endmodule

//--- design/rom_req_queue.sv
// Credits start at ROM_CREDITS and return one per rom_credit pulse, capped at the start value.
// A ROM read arriving at a full queue is dropped and sets overflow until reset.
`timescale 1ns/100ps

module rom_req_queue import cart_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  logic     access_valid,
  input  access_t  access,
  input  decode_t  decode,
  input  logic     rom_credit,
  output logic     rom_req_valid,
  output rom_req_t rom_req,
  output logic     overflow
);

  rom_req_t               mem [ROM_QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic [CREDIT_W-1:0]    credits;
  logic                   push_req;
  logic                   push;
  logic                   issue;
  logic                   full;

  assign push_req = access_valid && !access.wr && decode.rom_hit;
  assign full     = (count == QUEUE_CNT_W'(ROM_QUEUE_DEPTH));
  assign issue    = (count != '0) && (credits != '0);

  // A full queue still takes an entry when one leaves in the same cycle
  assign push = push_req && (!full || issue);

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= '{rom_addr: decode.rom_addr};
    end
    if (issue) begin
      rom_req <= mem[rd_ptr];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credits       <= CREDIT_W'(ROM_CREDITS);
      rom_req_valid <= 1'b0;
      overflow      <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == QUEUE_PTR_W'(ROM_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr <= (rd_ptr == QUEUE_PTR_W'(ROM_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      case ({push, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // An issue and a returned credit in the same cycle cancel out
      case ({issue, rom_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: begin
          if (credits != CREDIT_W'(ROM_CREDITS)) begin
            credits <= credits + 1'b1;
          end
        end
        default: credits <= credits;
      endcase

      rom_req_valid <= issue;

      if (push_req && !push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

//--- design/address_decoder.sv
// Purely combinational, valid in the same cycle as the bus snapshot.
// Save-RAM is not mapped, so every ROMSEL access is a ROM hit.
`timescale 1ns/100ps

module address_decoder import cart_pkg::*; (
  input  snes_bus_t   bus,
  input  logic [15:0] featurebits,
  output decode_t     decode
);

  logic [15:0] low_addr;
  logic        bank_low;
  logic        msu_window;
  logic        sgb_window;
  logic        button_word;

  assign low_addr = bus.addr[15:0];
  assign bank_low = !bus.addr[22];

  assign msu_window = bank_low && ((low_addr & MSU_MASK) == MSU_BASE);

  // Three overlapping SGB register patterns in banks $00-$3F and $80-$BF
  assign sgb_window = bank_low &&
                      (((low_addr & SGB_MASK_A) == SGB_BASE_A) ||
                       ((low_addr & SGB_MASK_B) == SGB_BASE_B) ||
                       ((low_addr & SGB_MASK_C) == SGB_BASE_C));

  // Buttons sit at offsets 1 and 2 of a four-byte block
  assign button_word = ({bus.addr[23:2], 2'b00} == BUTTON_BASE) &&
                       (bus.addr[1] != bus.addr[0]);

  always_comb begin
    decode = '0;

    decode.is_rom      = ~bus.romsel;
    decode.is_saveram  = 1'b0;
    decode.is_writable = decode.is_saveram;
    decode.rom_hit     = decode.is_rom | decode.is_saveram;

    // LoROM folding drops bank bits 23:20 and address bit 15
    decode.rom_addr = {5'h00, bus.addr[19:16], bus.addr[14:0]};

    decode.msu_enable = featurebits[FEAT_MSU] & msu_window;
    decode.sgb_enable = sgb_window;

    decode.r213f_enable = featurebits[FEAT_213F] & (bus.pa == R213F_PA);
    decode.r2100_hit    = (bus.pa == R2100_PA);

    decode.snescmd_enable = ({bus.addr[22], bus.addr[15:9]} == SNESCMD_PAGE);

    // Offset 1 selects the high pad byte, offset 2 the low one
    decode.button_enable = button_word;
    decode.button_addr   = bus.addr[0];
  end

endmodule

//--- design/bus_sync.sv
// Console pins are asynchronous to CLK and must stay stable for the sync depth.
// One event per strobe falling edge; a read and a write edge together count as a write.
`timescale 1ns/100ps

module bus_sync import cart_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_pa,
  input  logic        snes_romsel,
  input  logic        snes_rd_n,
  input  logic        snes_wr_n,
  input  logic [7:0]  snes_data,
  output logic        access_valid,
  output access_t     access
);

  snes_bus_t                        bus_in;
  snes_bus_t [SYNC_STAGES-1:0]      bus_q;
  logic [SYNC_STAGES-1:0][7:0]      data_q;
  logic [SYNC_STAGES-1:0]           rd_n_q;
  logic [SYNC_STAGES-1:0]           wr_n_q;
  logic                             rd_n_prev;
  logic                             wr_n_prev;
  logic                             rd_fall;
  logic                             wr_fall;
  snes_bus_t                        bus_s;

  assign bus_in = '{addr: snes_addr, pa: snes_pa, romsel: snes_romsel};
  assign bus_s  = bus_q[SYNC_STAGES-1];

  // Address and data lines carry no reset, only the strobes need a known idle level
  always_ff @(posedge CLK) begin
    bus_q[0]  <= bus_in;
    data_q[0] <= snes_data;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      bus_q[i]  <= bus_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_n_q    <= '1;
      wr_n_q    <= '1;
      rd_n_prev <= 1'b1;
      wr_n_prev <= 1'b1;
    end else begin
      rd_n_q    <= {rd_n_q[SYNC_STAGES-2:0], snes_rd_n};
      wr_n_q    <= {wr_n_q[SYNC_STAGES-2:0], snes_wr_n};
      rd_n_prev <= rd_n_q[SYNC_STAGES-1];
      wr_n_prev <= wr_n_q[SYNC_STAGES-1];
    end
  end

  assign rd_fall = rd_n_prev & ~rd_n_q[SYNC_STAGES-1];
  assign wr_fall = wr_n_prev & ~wr_n_q[SYNC_STAGES-1];

  always_ff @(posedge CLK) begin
    if (rst) begin
      access_valid <= 1'b0;
    end else begin
      access_valid <= rd_fall | wr_fall;
    end
  end

  // The event payload holds until the next strobe edge
  always_ff @(posedge CLK) begin
    if (rd_fall | wr_fall) begin
      access.bus      <= bus_s;
      access.wr       <= wr_fall;
      access.wdata    <= data_q[SYNC_STAGES-1];
      access.pa_cycle <= !bus_s.addr[22] && (bus_s.addr[15:8] == BBUS_PAGE);
    end
  end

endmodule

//--- design/cart_pkg.sv
// Shared types and constants for the cartridge bus interface.
// Save-RAM is absent in this build, so its decode fields stay low.
package cart_pkg;

  // Feature register bit positions
  localparam int FEAT_REGION = 0;
  localparam int FEAT_MSU    = 3;
  localparam int FEAT_213F   = 4;

  // Console address map
  localparam logic [23:0] BUTTON_BASE   = 24'h010F10;
  localparam logic [7:0]  SNESCMD_PAGE  = 8'b0_0010101;
  localparam logic [7:0]  BBUS_PAGE     = 8'h21;
  localparam logic [15:0] MSU_MASK      = 16'hfff8;
  localparam logic [15:0] MSU_BASE      = 16'h2000;
  localparam logic [15:0] SGB_MASK_A    = 16'hf808;
  localparam logic [15:0] SGB_BASE_A    = 16'h6000;
  localparam logic [15:0] SGB_MASK_B    = 16'hf80f;
  localparam logic [15:0] SGB_BASE_B    = 16'h600f;
  localparam logic [15:0] SGB_MASK_C    = 16'hf000;
  localparam logic [15:0] SGB_BASE_C    = 16'h7000;
  localparam logic [7:0]  R213F_PA      = 8'h3f;
  localparam logic [7:0]  R2100_PA      = 8'h00;

  // $213F read value, the region bit is filled in from the feature register
  localparam logic [7:0]  R213F_VALUE      = 8'h01;
  localparam int          R213F_REGION_BIT = 4;

  // Command window RAM covers one 512-byte page pair
  localparam int CMD_RAM_BYTES = 512;
  localparam int CMD_ADDR_W    = $clog2(CMD_RAM_BYTES);

  // Memory controller flow control and queueing
  localparam int ROM_CREDITS     = 4;
  localparam int ROM_QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W     = $clog2(ROM_QUEUE_DEPTH);
  localparam int QUEUE_CNT_W     = $clog2(ROM_QUEUE_DEPTH + 1);
  localparam int CREDIT_W        = $clog2(ROM_CREDITS + 1);

  localparam int SYNC_STAGES = 2;

  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  pa;
    logic        romsel;
  } snes_bus_t;

  typedef struct packed {
    logic [23:0] rom_addr;
    logic        rom_hit;
    logic        is_saveram;
    logic        is_rom;
    logic        is_writable;
    logic        msu_enable;
    logic        sgb_enable;
    logic        r213f_enable;
    logic        r2100_hit;
    logic        snescmd_enable;
    logic        button_enable;
    logic        button_addr;
  } decode_t;

  // One console cycle, pa_cycle marks an access to the B-bus page
  typedef struct packed {
    snes_bus_t   bus;
    logic        wr;
    logic [7:0]  wdata;
    logic        pa_cycle;
  } access_t;

  typedef struct packed {
    logic [23:0] rom_addr;
  } rom_req_t;

endpackage
